//--- filelist.f
+incdir+common
common/pinmux_pkg.sv
pwm/pwm_tick_gen.sv
pwm/pwm_channel.sv
verilog/pad_mux.sv
verilog/pinmux_apb_regs.sv
verilog/pinmux_top.sv
testbench/pinmux_sva.sv
testbench/tb_pinmux_top.sv

//--- Bender.yml
package:
  name: pinmux

export_include_dirs:
  - common

sources:
  - common/pinmux_pkg.sv
  - pwm/pwm_tick_gen.sv
  - pwm/pwm_channel.sv
  - verilog/pad_mux.sv
  - verilog/pinmux_apb_regs.sv
  - verilog/pinmux_top.sv
  - target: test
    files:
      - testbench/pinmux_sva.sv
      - testbench/tb_pinmux_top.sv

//--- testbench/tb_pinmux_top.sv
// Pinmux testbench with APB tasks, reference model, pad compare process, PWM duty checks and timeout
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module tb_pinmux_top;
   import pinmux_pkg::*;

   localparam int NP         = `PINMUX_NUM_PADS;
   localparam int NC         = `PINMUX_NUM_PWM;
   localparam int CW         = `PINMUX_CNT_W;
   localparam int DIV        = `PINMUX_TICK_DIV;
   localparam int MAX_PERIOD = 12;
   // Three PWM windows per channel at MAX_PERIOD plus register traffic with wide margin
   localparam int TIMEOUT_CYCLES = 4000;

   // Expected register contents
   typedef struct packed {
      logic [NP-1:0]          pad_out;
      logic [NP-1:0]          pad_dir;
      logic [NC-1:0]          pwm_sel;
      logic [NC-1:0]          enable;
      logic [NC-1:0][CW-1:0]  period;
      logic [NC-1:0][CW-1:0]  high;
   } shadow_t;

   // Expected pads and APB response
   typedef struct packed {
      logic [NP-1:0]  pad_out;
      logic [NP-1:0]  pad_oen;
      logic [31:0]    rdata;
      logic           err;
   } model_t;

   logic           mclk;
   logic           reset_i;
   apb_req_t       apb_req;
   apb_rsp_t       apb_rsp;
   logic [NP-1:0]  pad_in;
   logic [NP-1:0]  pad_out;
   logic [NP-1:0]  pad_oen;
   shadow_t        shadow;
   logic           pad_check_en;
   int             errors    = 0;
   int             checks    = 0;
   int             cycle_cnt = 0;

   pinmux_top i_pinmux_top (
      .mclk       (mclk    ),
      .reset_i    (reset_i ),
      .apb_req_i  (apb_req ),
      .apb_rsp_o  (apb_rsp ),
      .pad_in_i   (pad_in  ),
      .pad_out_o  (pad_out ),
      .pad_oen_o  (pad_oen )
   );

   always #5 mclk = ~mclk;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic model_t pinmux_model(input shadow_t sh, input logic [NP-1:0] pin,
                                           input logic [7:0] addr, input logic wr);
      model_t m;
      int     ch;
      int     off;
      m       = '0;
      m.pad_out = sh.pad_out;
      m.pad_oen = ~sh.pad_dir;
      // Selected pad is always driven
      // Output only known for an idle channel
      for (int c = 0; c < NC; c++) begin
         if (sh.pwm_sel[c]) begin
            m.pad_out[c] = 1'b0;
            m.pad_oen[c] = 1'b0;
         end
      end
      ch  = (int'(addr) - int'(`PINMUX_PWM_BASE)) / `PINMUX_PWM_STRIDE;
      off = (int'(addr) - int'(`PINMUX_PWM_BASE)) % `PINMUX_PWM_STRIDE;
      case (addr)
         `PINMUX_PAD_OUT: m.rdata = 32'(sh.pad_out);
         `PINMUX_PAD_DIR: m.rdata = 32'(sh.pad_dir);
         `PINMUX_PWM_SEL: m.rdata = 32'(sh.pwm_sel);
         `PINMUX_PAD_IN: begin
            m.rdata = 32'(pin);
            // Read-only word
            m.err   = wr;
         end
         default: begin
            if (addr >= `PINMUX_PWM_BASE && ch < NC && off == 0) begin
               m.rdata[31]     = sh.enable[ch];
               m.rdata[CW-1:0] = sh.period[ch];
            end else if (addr >= `PINMUX_PWM_BASE && ch < NC && off == 4) begin
               m.rdata[CW-1:0] = sh.high[ch];
            end else begin
               m.err = 1'b1;
            end
         end
      endcase
      if (m.err) begin
         m.rdata = '0;
      end
      return m;
   endfunction

   // Register update for one accepted write
   function automatic shadow_t shadow_write(input shadow_t sh, input logic [7:0] addr,
                                            input logic [31:0] data);
      shadow_t s;
      int      ch;
      int      off;
      s   = sh;
      ch  = (int'(addr) - int'(`PINMUX_PWM_BASE)) / `PINMUX_PWM_STRIDE;
      off = (int'(addr) - int'(`PINMUX_PWM_BASE)) % `PINMUX_PWM_STRIDE;
      if (addr == `PINMUX_PAD_OUT) begin
         s.pad_out = data[NP-1:0];
      end else if (addr == `PINMUX_PAD_DIR) begin
         s.pad_dir = data[NP-1:0];
      end else if (addr == `PINMUX_PWM_SEL) begin
         s.pwm_sel = data[NC-1:0];
      end else if (addr >= `PINMUX_PWM_BASE && ch < NC && off == 0) begin
         s.enable[ch] = data[31];
         s.period[ch] = data[CW-1:0];
      end else if (addr >= `PINMUX_PWM_BASE && ch < NC && off == 4) begin
         s.high[ch] = data[CW-1:0];
      end
      return s;
   endfunction

   function automatic logic [7:0] chan_addr(input int c, input int off);
      return 8'(`PINMUX_PWM_BASE + `PINMUX_PWM_STRIDE * c + off);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   // ------------------------------
   // APB transfers
   // ------------------------------
   task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] data);
      model_t m;
      m = pinmux_model(shadow, pad_in, addr, 1'b1);
      @(posedge mclk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
      @(posedge mclk);
      apb_req.penable <= 1'b1;
      @(negedge mclk);
      check_value({name, " pready"}, 32'd1, 32'(apb_rsp.pready));
      check_value({name, " pslverr"}, 32'(m.err), 32'(apb_rsp.pslverr));
      // Rejected write returns no data
      if (m.err) begin
         check_value({name, " prdata"}, 32'd0, apb_rsp.prdata);
      end
      // Write edge
      @(posedge mclk);
      apb_req <= '0;
      if (!m.err) begin
         shadow = shadow_write(shadow, addr, data);
      end
   endtask

   task automatic read_check(input string name, input logic [7:0] addr);
      model_t m;
      @(posedge mclk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
      @(posedge mclk);
      apb_req.penable <= 1'b1;
      @(negedge mclk);
      m = pinmux_model(shadow, pad_in, addr, 1'b0);
      check_value({name, " pready"}, 32'd1, 32'(apb_rsp.pready));
      check_value({name, " rdata"}, m.rdata, apb_rsp.prdata);
      check_value({name, " pslverr"}, 32'(m.err), 32'(apb_rsp.pslverr));
      @(posedge mclk);
      apb_req <= '0;
   endtask

   task automatic read_all_regs(input string tag);
      read_check({tag, " pad_out"}, `PINMUX_PAD_OUT);
      read_check({tag, " pad_dir"}, `PINMUX_PAD_DIR);
      read_check({tag, " pwm_sel"}, `PINMUX_PWM_SEL);
      for (int c = 0; c < NC; c++) begin
         read_check($sformatf("%s ch%0d ctrl", tag, c), chan_addr(c, `PINMUX_PWM_CTRL_OFF));
         read_check($sformatf("%s ch%0d high", tag, c), chan_addr(c, `PINMUX_PWM_HIGH_OFF));
      end
   endtask

   // ------------------------------
   // Pad compare and timeout
   // ------------------------------
   always @(negedge mclk) begin : compare_pads
      model_t m;
      if (pad_check_en) begin
         m = pinmux_model(shadow, pad_in, `PINMUX_PAD_OUT, 1'b0);
         check_value("pad_out", 32'(m.pad_out), 32'(pad_out));
         check_value("pad_oen", 32'(m.pad_oen), 32'(pad_oen));
      end
   end

   always @(posedge mclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      int     period_v [NC];
      int     high_v [NC];
      int     hi_cnt;
      int     exp_cnt;
      int     sva_fails;
      model_t m;
      mclk         = 1'b0;
      reset_i      = 1'b1;
      apb_req      = '0;
      pad_in       = '0;
      shadow       = '0;
      pad_check_en = 1'b0;
      void'($urandom(75565));
      repeat (4) @(posedge mclk);
      reset_i <= 1'b0;
      @(posedge mclk);
      pad_check_en = 1'b1;

      // Random register values and readback
      apb_write("wr pad_out", `PINMUX_PAD_OUT, $urandom);
      apb_write("wr pad_dir", `PINMUX_PAD_DIR, $urandom);
      for (int c = 0; c < NC; c++) begin
         apb_write($sformatf("wr ch%0d ctrl", c), chan_addr(c, `PINMUX_PWM_CTRL_OFF), $urandom);
         apb_write($sformatf("wr ch%0d high", c), chan_addr(c, `PINMUX_PWM_HIGH_OFF), $urandom);
      end
      read_all_regs("readback");

      // Unmapped offsets and the read-only input word
      read_check("unmapped 0x10", 8'h10);
      read_check("unmapped 0x42", 8'h42);
      read_check("unmapped 0x60", 8'h60);
      read_check("unmapped 0x84", 8'h84);
      apb_write("wr pad_in", `PINMUX_PAD_IN, $urandom);
      apb_write("wr unmapped 0xc0", 8'hC0, $urandom);
      read_all_regs("after errors");

      // Software pad path checked each cycle by compare_pads
      repeat (6) begin
         apb_write("wr pad_out", `PINMUX_PAD_OUT, $urandom);
         apb_write("wr pad_dir", `PINMUX_PAD_DIR, $urandom);
      end

      // Pad input synchronizer
      repeat (4) begin
         @(posedge mclk);
         pad_in <= NP'($urandom);
         repeat (3) @(posedge mclk);
         read_check("pad_in", `PINMUX_PAD_IN);
      end

      // PWM duty over three periods per channel
      for (int c = 0; c < NC; c++) begin
         period_v[c] = 2 + ($urandom % (MAX_PERIOD - 1));
         high_v[c]   = $urandom % (period_v[c] + 2);
         apb_write("wr pwm high", chan_addr(c, `PINMUX_PWM_HIGH_OFF), 32'(high_v[c]));
         apb_write("wr pwm ctrl", chan_addr(c, `PINMUX_PWM_CTRL_OFF),
                   {1'b1, 15'd0, 16'(period_v[c])});
      end
      pad_check_en = 1'b0;
      apb_write("wr pwm_sel", `PINMUX_PWM_SEL, 32'hF);
      repeat (MAX_PERIOD * DIV + 4) @(posedge mclk);
      for (int c = 0; c < NC; c++) begin
         hi_cnt = 0;
         repeat (3 * period_v[c] * DIV) begin
            @(negedge mclk);
            hi_cnt += pad_out[c];
         end
         exp_cnt = 3 * ((high_v[c] < period_v[c]) ? high_v[c] : period_v[c]) * DIV;
         check_value($sformatf("ch%0d high cycles", c), exp_cnt, hi_cnt);
         check_value($sformatf("ch%0d oen", c), 32'd0, 32'(pad_oen[c]));
      end

      // Disabled channel drives its pad low
      for (int c = 0; c < NC; c++) begin
         apb_write("wr pwm off", chan_addr(c, `PINMUX_PWM_CTRL_OFF), 32'(period_v[c]));
         repeat (2) @(posedge mclk);
         repeat (16) begin
            @(negedge mclk);
            m = pinmux_model(shadow, pad_in, `PINMUX_PAD_OUT, 1'b0);
            check_value($sformatf("ch%0d off pad", c), 32'(m.pad_out[c]), 32'(pad_out[c]));
         end
      end

      sva_fails = i_pinmux_top.i_pinmux_sva.fail_count;
      $display("Checks: %0d  Errors: %0d  Assertion failures: %0d", checks, errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/pinmux_sva.sv
// Concurrent APB handshake and pad reset assertions with their bind into the pinmux top level
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_sva (
   input logic                          mclk,
   input logic                          reset_i,
   input pinmux_pkg::apb_req_t          apb_req_i,
   input pinmux_pkg::apb_rsp_t          apb_rsp_i,
   input logic [`PINMUX_NUM_PADS-1:0]   pad_out_i,
   input logic [`PINMUX_NUM_PADS-1:0]   pad_oen_i
);

   // Number of assertion failures so far
   int fail_count = 0;

   // ------------------------------
   // APB response
   // ------------------------------
   // Ready only in the access phase
   a_pready_access: assert property (@(posedge mclk) disable iff (reset_i)
      apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
      else begin
         $error("pready high outside an APB access cycle");
         fail_count++;
      end

   a_pslverr_ready: assert property (@(posedge mclk) disable iff (reset_i)
      apb_rsp_i.pslverr |-> apb_rsp_i.pready)
      else begin
         $error("pslverr high without pready");
         fail_count++;
      end

   // ------------------------------
   // Reset state
   // ------------------------------
   a_reset_pads: assert property (@(posedge mclk)
      reset_i |=> ((pad_oen_i == '1) && (pad_out_i == '0)))
      else begin
         $error("pads not idle in the cycle after reset");
         fail_count++;
      end

   a_reset_ready: assert property (@(posedge mclk)
      reset_i |=> !apb_rsp_i.pready && !apb_rsp_i.pslverr)
      else begin
         $error("APB response active in the cycle after reset");
         fail_count++;
      end

endmodule

bind pinmux_top pinmux_sva i_pinmux_sva (
   .mclk       (mclk      ),
   .reset_i    (reset_i   ),
   .apb_req_i  (apb_req_i ),
   .apb_rsp_i  (apb_rsp_o ),
   .pad_out_i  (pad_out_o ),
   .pad_oen_i  (pad_oen_o )
);

`default_nettype wire

//--- verilog/pinmux_top.sv
// Pinmux top: register block, tick generator, PWM channel array and pad multiplexer
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_top (
   input  logic                          mclk,
   input  logic                          reset_i,
   // APB register port
   input  pinmux_pkg::apb_req_t          apb_req_i,
   output pinmux_pkg::apb_rsp_t          apb_rsp_o,
   // Pads
   input  logic [`PINMUX_NUM_PADS-1:0]   pad_in_i,
   output logic [`PINMUX_NUM_PADS-1:0]   pad_out_o,
   output logic [`PINMUX_NUM_PADS-1:0]   pad_oen_o
);
   import pinmux_pkg::*;

   // Channel register traffic
   pwm_cfg_t [`PINMUX_NUM_PWM-1:0]   pwm_cfg;
   pwm_wr_t  [`PINMUX_NUM_PWM-1:0]   pwm_wr;
   // Waveforms and pad select
   logic     [`PINMUX_NUM_PWM-1:0]   pwm_wfm;
   logic     [`PINMUX_NUM_PWM-1:0]   pwm_sel;
   // Software pad registers
   logic     [`PINMUX_NUM_PADS-1:0]  pad_out;
   logic     [`PINMUX_NUM_PADS-1:0]  pad_dir;
   // Shared time base
   logic                             tick;

   // ------------------------------
   // Register block
   // ------------------------------
   pinmux_apb_regs u_apb_regs (
      .mclk       (mclk      ),
      .reset_i    (reset_i   ),
      .apb_req_i  (apb_req_i ),
      .apb_rsp_o  (apb_rsp_o ),
      .pad_in_i   (pad_in_i  ),
      .pwm_cfg_i  (pwm_cfg   ),
      .pwm_wr_o   (pwm_wr    ),
      .pad_out_o  (pad_out   ),
      .pad_dir_o  (pad_dir   ),
      .pwm_sel_o  (pwm_sel   )
   );

   // ------------------------------
   // PWM
   // ------------------------------
   pwm_tick_gen u_tick_gen (
      .mclk       (mclk      ),
      .reset_i    (reset_i   ),
      .tick_o     (tick      )
   );

   // One channel per waveform, channel c feeds pad c
   for (genvar c = 0; c < `PINMUX_NUM_PWM; c++) begin : g_pwm
      pwm_channel u_pwm_channel (
         .mclk       (mclk        ),
         .reset_i    (reset_i     ),
         .tick_i     (tick        ),
         .pwm_wr_i   (pwm_wr[c]   ),
         .pwm_cfg_o  (pwm_cfg[c]  ),
         .pwm_wfm_o  (pwm_wfm[c]  )
      );
   end

   // ------------------------------
   // Pad multiplexer
   // ------------------------------
   pad_mux u_pad_mux (
      .pwm_wfm_i  (pwm_wfm   ),
      .pwm_sel_i  (pwm_sel   ),
      .pad_out_i  (pad_out   ),
      .pad_dir_i  (pad_dir   ),
      .pad_out_o  (pad_out_o ),
      .pad_oen_o  (pad_oen_o )
   );

endmodule

`default_nettype wire

//--- verilog/pinmux_apb_regs.sv
// APB slave with block decode, pad registers, input synchronizer and read mux
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_apb_regs (
   input  logic                                       mclk,
   input  logic                                       reset_i,
   input  pinmux_pkg::apb_req_t                       apb_req_i,
   output pinmux_pkg::apb_rsp_t                       apb_rsp_o,
   input  logic [`PINMUX_NUM_PADS-1:0]                pad_in_i,
   input  pinmux_pkg::pwm_cfg_t [`PINMUX_NUM_PWM-1:0] pwm_cfg_i,
   output pinmux_pkg::pwm_wr_t  [`PINMUX_NUM_PWM-1:0] pwm_wr_o,
   output logic [`PINMUX_NUM_PADS-1:0]                pad_out_o,
   output logic [`PINMUX_NUM_PADS-1:0]                pad_dir_o,
   output logic [`PINMUX_NUM_PWM-1:0]                 pwm_sel_o
);
   import pinmux_pkg::*;

   localparam int NP      = `PINMUX_NUM_PADS;
   localparam int NC      = `PINMUX_NUM_PWM;
   localparam int DW      = `PINMUX_DATA_W;
   localparam int AW      = `PINMUX_ADDR_W;
   localparam int CW      = `PINMUX_CNT_W;
   localparam int BLK_BIT = `PINMUX_BLK_BIT;

   logic           access;
   logic           upper_ok;
   blk_sel_e       blk_sel;
   logic [AW-1:0]  pwm_off;
   logic [AW-1:0]  ch_idx;
   logic [AW-1:0]  ch_off;
   pwm_reg_e       reg_sel;
   logic           hit_pad_out;
   logic           hit_pad_dir;
   logic           hit_pwm_sel;
   logic           hit_pad_in;
   logic           hit_pwm;
   logic           addr_err;
   logic           wr_err;
   logic           wr_en;
   logic [NP-1:0]  pad_out_q;
   logic [NP-1:0]  pad_dir_q;
   logic [NC-1:0]  pwm_sel_q;
   logic [NP-1:0]  pad_in_s1;
   logic [NP-1:0]  pad_in_s2;
   pwm_cfg_t       sel_cfg;
   logic [DW-1:0]  rdata;

   // ------------------------------
   // Address decode
   // ------------------------------
   // Access phase only, setup phase does nothing
   assign access   = apb_req_i.psel & apb_req_i.penable;
   assign blk_sel  = apb_req_i.paddr[BLK_BIT] ? BLK_PWM : BLK_PAD;
   // Bits above the group bit must be clear
   assign upper_ok = (apb_req_i.paddr[AW-1:BLK_BIT+1] == '0);

   // Pad group, full offset match
   assign hit_pad_out = upper_ok && (blk_sel == BLK_PAD) && (apb_req_i.paddr == `PINMUX_PAD_OUT);
   assign hit_pad_dir = upper_ok && (blk_sel == BLK_PAD) && (apb_req_i.paddr == `PINMUX_PAD_DIR);
   assign hit_pwm_sel = upper_ok && (blk_sel == BLK_PAD) && (apb_req_i.paddr == `PINMUX_PWM_SEL);
   assign hit_pad_in  = upper_ok && (blk_sel == BLK_PAD) && (apb_req_i.paddr == `PINMUX_PAD_IN);

   // PWM group, channel index and word inside the channel
   assign pwm_off = apb_req_i.paddr - `PINMUX_PWM_BASE;
   assign ch_idx  = pwm_off / `PINMUX_PWM_STRIDE;
   assign ch_off  = pwm_off % `PINMUX_PWM_STRIDE;
   assign reg_sel = (ch_off == `PINMUX_PWM_HIGH_OFF) ? PWM_REG_HIGH : PWM_REG_CTRL;
   assign hit_pwm = upper_ok && (blk_sel == BLK_PWM) && (ch_idx < NC) &&
                    ((ch_off == `PINMUX_PWM_CTRL_OFF) || (ch_off == `PINMUX_PWM_HIGH_OFF));

   // Error cases: nothing mapped, or a write to the read-only input word
   assign addr_err = ~(hit_pad_out | hit_pad_dir | hit_pwm_sel | hit_pad_in | hit_pwm);
   assign wr_err   = apb_req_i.pwrite & hit_pad_in;
   assign wr_en    = access & apb_req_i.pwrite & ~addr_err & ~wr_err;

   // ------------------------------
   // Pad group registers
   // ------------------------------
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         pad_out_q <= '0;
         pad_dir_q <= '0;
         pwm_sel_q <= '0;
      end else if (wr_en) begin
         if (hit_pad_out) begin
            pad_out_q <= apb_req_i.pwdata[NP-1:0];
         end
         if (hit_pad_dir) begin
            pad_dir_q <= apb_req_i.pwdata[NP-1:0];
         end
         if (hit_pwm_sel) begin
            pwm_sel_q <= apb_req_i.pwdata[NC-1:0];
         end
      end
   end

   assign pad_out_o = pad_out_q;
   assign pad_dir_o = pad_dir_q;
   assign pwm_sel_o = pwm_sel_q;

   // Two-flop synchronizer on the pad inputs
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         pad_in_s1 <= '0;
         pad_in_s2 <= '0;
      end else begin
         pad_in_s1 <= pad_in_i;
         pad_in_s2 <= pad_in_s1;
      end
   end

   // ------------------------------
   // PWM write routing
   // ------------------------------
   always_comb begin
      for (int c = 0; c < NC; c++) begin
         // Strobe only for the addressed channel
         pwm_wr_o[c].we      = wr_en & hit_pwm & (ch_idx == c);
         pwm_wr_o[c].reg_sel = reg_sel;
         pwm_wr_o[c].enable  = apb_req_i.pwdata[`PINMUX_CTRL_EN_BIT];
         pwm_wr_o[c].wdata   = apb_req_i.pwdata[CW-1:0];
      end
   end

   // ------------------------------
   // Read data
   // ------------------------------
   // Addressed channel config, zero when out of range
   always_comb begin
      sel_cfg = '0;
      for (int c = 0; c < NC; c++) begin
         if (ch_idx == c) begin
            sel_cfg = pwm_cfg_i[c];
         end
      end
   end

   always_comb begin
      rdata = '0;
      if (hit_pad_out) begin
         rdata[NP-1:0] = pad_out_q;
      end else if (hit_pad_dir) begin
         rdata[NP-1:0] = pad_dir_q;
      end else if (hit_pwm_sel) begin
         rdata[NC-1:0] = pwm_sel_q;
      end else if (hit_pad_in) begin
         rdata[NP-1:0] = pad_in_s2;
      end else if (hit_pwm && (reg_sel == PWM_REG_CTRL)) begin
         // Enable on top, period in the low half
         rdata[`PINMUX_CTRL_EN_BIT] = sel_cfg.enable;
         rdata[CW-1:0]              = sel_cfg.period;
      end else if (hit_pwm) begin
         rdata[CW-1:0] = sel_cfg.high;
      end
   end

   // No wait states, response only in the access cycle
   always_comb begin
      apb_rsp_o.pready  = access;
      apb_rsp_o.pslverr = access & (addr_err | wr_err);
      apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite & ~addr_err) ? rdata : '0;
   end

endmodule

`default_nettype wire

//--- verilog/pad_mux.sv
// Per-pad choice between PWM waveform and software output, with output enables
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module pad_mux (
   input  logic [`PINMUX_NUM_PWM-1:0]   pwm_wfm_i,
   input  logic [`PINMUX_NUM_PWM-1:0]   pwm_sel_i,
   input  logic [`PINMUX_NUM_PADS-1:0]  pad_out_i,
   input  logic [`PINMUX_NUM_PADS-1:0]  pad_dir_i,
   output logic [`PINMUX_NUM_PADS-1:0]  pad_out_o,
   output logic [`PINMUX_NUM_PADS-1:0]  pad_oen_o
);

   localparam int NP = `PINMUX_NUM_PADS;
   localparam int NC = `PINMUX_NUM_PWM;

   // ------------------------------
   // Pads with a PWM channel
   // ------------------------------
   for (genvar p = 0; p < NP; p++) begin : g_pad
      if (p < NC) begin : g_pwm_pad
         // Selected waveform always drives the pad
         assign pad_out_o[p] = pwm_sel_i[p] ? pwm_wfm_i[p] : pad_out_i[p];
         assign pad_oen_o[p] = pwm_sel_i[p] ? 1'b0 : ~pad_dir_i[p];
      end else begin : g_sw_pad
         // Software pad only
         // oen is active low, dir 1 means output
         assign pad_out_o[p] = pad_out_i[p];
         assign pad_oen_o[p] = ~pad_dir_i[p];
      end
   end

endmodule

`default_nettype wire

//--- pwm/pwm_channel.sv
// One PWM channel: control and high registers, period counter, registered waveform
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module pwm_channel (
   input  logic                 mclk,
   input  logic                 reset_i,
   input  logic                 tick_i,
   input  pinmux_pkg::pwm_wr_t  pwm_wr_i,
   output pinmux_pkg::pwm_cfg_t pwm_cfg_o,
   output logic                 pwm_wfm_o
);
   import pinmux_pkg::*;

   localparam int CW = `PINMUX_CNT_W;

   logic           enable_q;
   logic [CW-1:0]  period_q;
   logic [CW-1:0]  high_q;
   logic [CW-1:0]  cnt_q;
   logic           run;
   logic           wfm_q;

   // ------------------------------
   // Config registers
   // ------------------------------
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         enable_q <= 1'b0;
         period_q <= '0;
         high_q   <= '0;
      end else if (pwm_wr_i.we) begin
         if (pwm_wr_i.reg_sel == PWM_REG_CTRL) begin
            enable_q <= pwm_wr_i.enable;
            period_q <= pwm_wr_i.wdata;
         end else begin
            high_q   <= pwm_wr_i.wdata;
         end
      end
   end

   assign pwm_cfg_o.enable = enable_q;
   assign pwm_cfg_o.period = period_q;
   assign pwm_cfg_o.high   = high_q;

   // ------------------------------
   // Period counter
   // ------------------------------
   // Zero period counts as stopped
   assign run = enable_q && (period_q != '0);

   always_ff @(posedge mclk) begin
      if (reset_i) begin
         cnt_q <= '0;
      end else if (!run) begin
         cnt_q <= '0;
      end else if (tick_i) begin
         // Also wraps if period was lowered under the count
         if (cnt_q >= period_q - 1'b1) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // High while count under the high value
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         wfm_q <= 1'b0;
      end else begin
         wfm_q <= run && (cnt_q < high_q);
      end
   end

   assign pwm_wfm_o = wfm_q;

endmodule

`default_nettype wire

//--- pwm/pwm_tick_gen.sv
// Prescaler giving a one-cycle tick every PINMUX_TICK_DIV clocks
`timescale 1ns/1ps
`default_nettype none
`include "pinmux_settings.svh"

module pwm_tick_gen (
   input  logic  mclk,
   input  logic  reset_i,
   output logic  tick_o
);

   localparam int DIV = `PINMUX_TICK_DIV;
   // At least one bit, even for a divide by one
   localparam int DW  = (DIV > 1) ? $clog2(DIV) : 1;

   logic [DW-1:0] div_cnt_q;
   logic          wrap;

   // Last count of the window
   assign wrap = (div_cnt_q == DW'(DIV - 1));

   // Free-running divider from reset release
   always_ff @(posedge mclk) begin
      if (reset_i) begin
         div_cnt_q <= '0;
      end else if (wrap) begin
         div_cnt_q <= '0;
      end else begin
         div_cnt_q <= div_cnt_q + 1'b1;
      end
   end

   // Shared time base for every channel
   assign tick_o = wrap;

endmodule

`default_nettype wire

//--- common/pinmux_pkg.sv
// Pinmux types: APB request and response, PWM write and config, select enums
`default_nettype none

package pinmux_pkg;

   `include "pinmux_settings.svh"

   // ------------------------------
   // APB
   // ------------------------------
   typedef struct packed {
      logic                       psel;
      logic                       penable;
      logic                       pwrite;
      logic [`PINMUX_ADDR_W-1:0]  paddr;
      logic [`PINMUX_DATA_W-1:0]  pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [`PINMUX_DATA_W-1:0]  prdata;
      logic                       pready;
      logic                       pslverr;
   } apb_rsp_t;

   // Register group, from the block address bit
   typedef enum logic {
      BLK_PAD = 1'b0,
      BLK_PWM = 1'b1
   } blk_sel_e;

   // Register inside one PWM channel
   typedef enum logic {
      PWM_REG_CTRL = 1'b0,
      PWM_REG_HIGH = 1'b1
   } pwm_reg_e;

   // ------------------------------
   // PWM channel
   // ------------------------------
   // Write into one channel
   // enable carries the control word enable bit
   typedef struct packed {
      logic                       we;
      pwm_reg_e                   reg_sel;
      logic                       enable;
      logic [`PINMUX_CNT_W-1:0]   wdata;
   } pwm_wr_t;

   // Channel register contents for readback
   typedef struct packed {
      logic                       enable;
      logic [`PINMUX_CNT_W-1:0]   period;
      logic [`PINMUX_CNT_W-1:0]   high;
   } pwm_cfg_t;

endpackage

`default_nettype wire

//--- common/pinmux_settings.svh
// Pinmux sizing, tick divider and register map macros
`ifndef PINMUX_SETTINGS_SVH
`define PINMUX_SETTINGS_SVH

// ------------------------------
// Sizing
// ------------------------------
`define PINMUX_NUM_PADS     16
`define PINMUX_NUM_PWM      4
`define PINMUX_DATA_W       32
`define PINMUX_ADDR_W       8
`define PINMUX_CNT_W        16
// Clocks per PWM tick, kept small for simulation
`define PINMUX_TICK_DIV     4

// ------------------------------
// Register map
// ------------------------------
`define PINMUX_PAD_OUT      8'h00
`define PINMUX_PAD_DIR      8'h04
`define PINMUX_PWM_SEL      8'h08
`define PINMUX_PAD_IN       8'h0C
`define PINMUX_PWM_BASE     8'h40
`define PINMUX_PWM_STRIDE   8
// Offsets within one channel
`define PINMUX_PWM_CTRL_OFF 0
`define PINMUX_PWM_HIGH_OFF 4
// Address bit picking the register group
`define PINMUX_BLK_BIT      6
// Enable position in the channel control word
`define PINMUX_CTRL_EN_BIT  31

`endif
